// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f sim.f \
		--top-module sample_generator_tb -Mdir obj_dir
	./obj_dir/Vsample_generator_tb +verilator+error+limit+100 | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: bench/sample_generator_properties.sv
`timescale 1ns/100ps

module sample_generator_properties #(
	parameter int DAC_STAGES = 5
) (
	input logic                 clk,
	input logic                 rst,
	input logic                 resp_valid,
	input logic                 dac_valid,
	input sample_pkg::src_sel_t sel
);
	import sample_pkg::*;

	int since_rst   = 0;
	int idle_cycles = 0;
	int assert_failures = 0;

	always_ff @(posedge clk) begin
		if (rst) begin
			since_rst <= 0;
		end else if (since_rst < DAC_STAGES) begin
			since_rst <= since_rst + 1;
		end
	end

	// Edges seen with no source selected, saturating at the pipe depth
	always_ff @(posedge clk) begin
		if (rst || sel != src_none) begin
			idle_cycles <= 0;
		end else if (idle_cycles < DAC_STAGES) begin
			idle_cycles <= idle_cycles + 1;
		end
	end

	resp_one_cycle: assert property (@(posedge clk) disable iff (rst)
		resp_valid |=> !resp_valid)
	else begin
		assert_failures++;
		$error("resp_valid stayed high for two cycles");
	end

	quiet_after_reset: assert property (@(posedge clk)
		(!rst && since_rst < DAC_STAGES) |-> !dac_valid)
	else begin
		assert_failures++;
		$error("dac_valid rose within the pipe depth after reset");
	end

	quiet_when_idle: assert property (@(posedge clk) disable iff (rst)
		(idle_cycles >= DAC_STAGES) |-> !dac_valid)
	else begin
		assert_failures++;
		$error("dac_valid high with no source selected for the whole pipe depth");
	end

endmodule

bind sample_generator sample_generator_properties #(
	.DAC_STAGES (DAC_STAGES)
) props_i (
	.clk        (clk),
	.rst        (rst),
	.resp_valid (resp_valid),
	.dac_valid  (dac_valid),
	.sel        (sel)
);

// File: include/sample_models.svh
`ifndef SAMPLE_MODELS_SVH
`define SAMPLE_MODELS_SVH

// Reference models of the three sample sources

function automatic logic [15:0] model_lfsr_step(logic [15:0] s);
	return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
endfunction

function automatic logic [15:0] model_lfsr_seed(logic [15:0] seed);
	return (seed == 16'h0000) ? 16'h0001 : seed;
endfunction

function automatic sample_pkg::batch_t model_lfsr_batch_step(sample_pkg::batch_t b);
	sample_pkg::batch_t r;
	for (int k = 0; k < sample_pkg::BATCH_SIZE; k++) begin
		r[k] = model_lfsr_step(b[k]);
	end
	return r;
endfunction

function automatic logic [15:0] model_tri_point(logic [16:0] p);
	return p[16] ? ~p[15:0] : p[15:0];
endfunction

// Phase is the accumulator value for lane 0
function automatic sample_pkg::batch_t model_tri_batch(logic [16:0] phase);
	sample_pkg::batch_t r;
	for (int k = 0; k < sample_pkg::BATCH_SIZE; k++) begin
		r[k] = model_tri_point(phase + 17'(k));
	end
	return r;
endfunction

function automatic logic [15:0] model_pwl_point(logic [15:0] start,
		logic signed [15:0] slope, int n);
	logic [15:0] idx;
	idx = n[15:0];
	return start + $unsigned(slope) * idx;
endfunction

// Batch b of a segment covers samples 4b to 4b+3
function automatic sample_pkg::batch_t model_pwl_batch(sample_pkg::pwl_seg_t seg, int b);
	sample_pkg::batch_t r;
	for (int k = 0; k < sample_pkg::BATCH_SIZE; k++) begin
		r[k] = model_pwl_point(seg.start, seg.slope, sample_pkg::BATCH_SIZE * b + k);
	end
	return r;
endfunction

`endif

// File: bench/sample_generator_tb.sv
`timescale 1ns/100ps

module sample_generator_tb;
	import sample_pkg::*;
	import host_cmd_pkg::*;

	`include "sample_models.svh"

	localparam int DAC_STAGES  = 5;
	localparam int PWL_DEPTH   = 16;
	localparam int TRI_BATCHES = 16400;
	localparam int HALT_AFTER  = 12;
	// Random ready is high about half the time, the other tests need a few hundred cycles
	localparam int CYCLE_LIMIT = 3 * TRI_BATCHES + 1000;

	logic      clk = 1'b0;
	logic      rst;
	host_cmd_t cmd;
	logic      cmd_valid;
	logic      dac_rdy;
	resp_t     resp;
	logic      resp_valid;
	batch_t    dac_batch;
	logic      dac_valid;

	batch_t exp_q[$];
	int     errors = 0;
	int     cycles = 0;
	integer seed;

	sample_generator #(
		.DAC_STAGES (DAC_STAGES),
		.PWL_DEPTH  (PWL_DEPTH)
	) dut_i (
		.clk        (clk),
		.rst        (rst),
		.cmd        (cmd),
		.cmd_valid  (cmd_valid),
		.dac_rdy    (dac_rdy),
		.resp       (resp),
		.resp_valid (resp_valid),
		.dac_batch  (dac_batch),
		.dac_valid  (dac_valid)
	);

	always #50 clk = ~clk;

	task automatic check_batch(input batch_t got, input batch_t exp, input string what);
		if (got !== exp) begin
			$display("error at %0t: %s got %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_resp(input resp_t got, input resp_t exp, input string what);
		if (got !== exp) begin
			$display("error at %0t: %s got %b, expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("error at %0t: %s got %b, expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	function automatic host_cmd_t make_cmd(opcode_t op, cmd_payload_u pl);
		host_cmd_t c;
		c.opcode  = op;
		c.payload = pl;
		return c;
	endfunction

	function automatic resp_t make_resp(logic ready, src_sel_t mode);
		resp_t r;
		r.pwl_ready = ready;
		r.mode      = mode;
		return r;
	endfunction

	function automatic pwl_seg_t make_seg(sample_t start, logic signed [15:0] slope,
			logic [15:0] length, logic last);
		pwl_seg_t s;
		s        = '0;
		s.start  = start;
		s.slope  = slope;
		s.length = length;
		s.last   = last;
		return s;
	endfunction

	// Returns one edge after the command was driven, when the DUT has taken it
	task automatic send_cmd(input opcode_t op, input cmd_payload_u pl);
		@(posedge clk);
		cmd       <= make_cmd(op, pl);
		cmd_valid <= 1'b1;
		@(posedge clk);
		cmd_valid <= 1'b0;
	endtask

	// Gives the running source exactly n ready cycles, with gaps if asked
	task automatic stream_batches(input int n, input bit gappy);
		int sent;
		bit rdy;
		sent = 0;
		while (sent < n) begin
			@(posedge clk);
			if (gappy) begin
				rdy = ($random(seed) & 1) != 0;
			end else begin
				rdy = 1'b1;
			end
			dac_rdy <= rdy;
			if (rdy) begin
				sent++;
			end
		end
		@(posedge clk);
		dac_rdy <= 1'b0;
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
		repeat (DAC_STAGES + 2) @(posedge clk);
	endtask

	// Every valid batch must be the next one the models predict
	always @(negedge clk) begin
		if (!rst && dac_valid) begin
			if (exp_q.size() == 0) begin
				$display("Unexpected valid batch %h at %0t while none was due", dac_batch, $time);
				errors++;
			end else begin
				check_batch(dac_batch, exp_q.pop_front(), "dac_batch");
			end
		end
	end

	task automatic reset_and_latency();
		batch_t st;
		@(negedge clk);
		check_bit(dac_valid, 1'b0, "dac_valid after reset");
		check_bit(resp_valid, 1'b0, "resp_valid after reset");
		check_resp(resp, make_resp(1'b0, src_none), "resp after reset");
		st = {16'd4, 16'd3, 16'd2, 16'd1};
		for (int i = 0; i < DAC_STAGES + 2; i++) begin
			exp_q.push_back(st);
			st = model_lfsr_batch_step(st);
		end
		@(posedge clk);
		cmd       <= make_cmd(op_run_rand, '0);
		cmd_valid <= 1'b1;
		dac_rdy   <= 1'b1;
		for (int e = 1; e <= DAC_STAGES + 1; e++) begin
			@(posedge clk);
			cmd_valid <= 1'b0;
			@(negedge clk);
			check_bit(dac_valid, e == DAC_STAGES + 1, "dac_valid latency");
		end
		send_cmd(op_halt, '0);
		dac_rdy <= 1'b0;
		wait_drain();
	endtask

	task automatic seeded_lfsr();
		batch_t       seeds;
		batch_t       st;
		cmd_payload_u pl;
		seeds = {16'hFFFF, 16'h1234, 16'h0000, 16'hACE1};
		for (int k = 0; k < BATCH_SIZE; k++) begin
			st[k] = model_lfsr_seed(seeds[k]);
		end
		for (int i = 0; i < 20; i++) begin
			exp_q.push_back(st);
			st = model_lfsr_batch_step(st);
		end
		pl.seeds = seeds;
		send_cmd(op_load_seeds, pl);
		send_cmd(op_run_rand, '0);
		stream_batches(20, 1'b0);
		wait_drain();
		send_cmd(op_halt, '0);
	endtask

	// Long enough to pass the top of the sweep at phase 0x10000
	task automatic triangle_with_gaps();
		for (int i = 0; i < TRI_BATCHES; i++) begin
			exp_q.push_back(model_tri_batch(17'(4 * i)));
		end
		send_cmd(op_run_tri, '0);
		stream_batches(TRI_BATCHES, 1'b1);
		wait_drain();
		send_cmd(op_halt, '0);
	endtask

	task automatic pwl_playback();
		pwl_seg_t     segs [3];
		cmd_payload_u pl;
		int           idx;
		int           b;
		segs[0] = make_seg(16'd100, 16'sd3, 16'd2, 1'b0);
		segs[1] = make_seg(16'hFFF0, -16'sd5, 16'd1, 1'b0);
		segs[2] = make_seg(16'h8000, 16'sd1000, 16'd3, 1'b1);
		for (int i = 0; i < 3; i++) begin
			pl.seg = segs[i];
			send_cmd(op_load_pwl, pl);
			@(negedge clk);
			check_bit(resp_valid, 1'b0, "resp_valid one edge after load");
			@(posedge clk);
			@(negedge clk);
			check_bit(resp_valid, i == 2, "resp_valid two edges after load");
			if (i == 2) begin
				check_resp(resp, make_resp(1'b1, src_none), "resp after table done");
			end
		end
		@(posedge clk);
		@(negedge clk);
		check_bit(resp_valid, 1'b0, "resp_valid pulse end");
		idx = 0;
		b   = 0;
		// Two full passes and one more batch, so the wrap to segment 0 is seen
		for (int i = 0; i < 13; i++) begin
			exp_q.push_back(model_pwl_batch(segs[idx], b));
			b++;
			if (b >= int'(segs[idx].length)) begin
				b   = 0;
				idx = (segs[idx].last || idx == PWL_DEPTH - 1) ? 0 : idx + 1;
			end
		end
		send_cmd(op_run_pwl, '0);
		@(negedge clk);
		check_resp(resp, make_resp(1'b1, src_pwl), "resp while playing");
		stream_batches(13, 1'b1);
		wait_drain();
		send_cmd(op_halt, '0);
	endtask

	task automatic halt_and_reset();
		for (int i = 0; i < HALT_AFTER; i++) begin
			exp_q.push_back(model_tri_batch(17'(4 * i)));
		end
		@(posedge clk);
		cmd       <= make_cmd(op_run_tri, '0);
		cmd_valid <= 1'b1;
		dac_rdy   <= 1'b1;
		@(posedge clk);
		cmd_valid <= 1'b0;
		repeat (HALT_AFTER - 2) @(posedge clk);
		// The source still advances in the halt cycle itself
		send_cmd(op_halt, '0);
		// Ready stays high here, so only the halt keeps further batches out of the pipe
		wait_drain();
		@(negedge clk);
		check_bit(dac_valid, 1'b0, "dac_valid after halt");
		@(posedge clk);
		dac_rdy <= 1'b0;
		for (int i = 0; i < 10; i++) begin
			exp_q.push_back(model_tri_batch(17'(4 * i)));
		end
		send_cmd(op_run_tri, '0);
		stream_batches(10, 1'b0);
		wait_drain();
		send_cmd(op_halt, '0);
		send_cmd(op_reset, '0);
		@(negedge clk);
		check_resp(resp, make_resp(1'b0, src_none), "resp after op_reset");
		send_cmd(op_run_pwl, '0);
		dac_rdy <= 1'b1;
		repeat (DAC_STAGES + 15) begin
			@(negedge clk);
			check_bit(dac_valid, 1'b0, "dac_valid with an empty table");
		end
		@(posedge clk);
		dac_rdy <= 1'b0;
		send_cmd(op_halt, '0);
	endtask

	initial begin
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, the expected batches never all arrived", cycles);
		$display("Test failed");
		$finish;
	end

	initial begin
		int failures;
		seed      = 74;
		rst       = 1'b1;
		cmd       = '0;
		cmd_valid = 1'b0;
		dac_rdy   = 1'b0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		reset_and_latency();
		seeded_lfsr();
		triangle_with_gaps();
		pwl_playback();
		halt_and_reset();
		if (exp_q.size() != 0) begin
			$display("%0d expected batches were never produced", exp_q.size());
			errors++;
		end
		failures = errors + dut_i.props_i.assert_failures;
		$display("Run finished with %0d check errors and %0d assertion failures",
			errors, dut_i.props_i.assert_failures);
		if (failures == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: hdl/dac_output_pipe.sv
`timescale 1ns/100ps

module dac_output_pipe #(
	parameter int DAC_STAGES = 5
) (
	input  logic                 clk,
	input  logic                 rst,
	input  sample_pkg::src_sel_t sel,
	input  sample_pkg::batch_t   rand_in,
	input  sample_pkg::batch_t   tri_in,
	input  sample_pkg::batch_t   pwl_in,
	input  logic                 rand_valid,
	input  logic                 tri_valid,
	input  logic                 pwl_valid,
	output sample_pkg::batch_t   dac_batch,
	output logic                 dac_valid
);
	import sample_pkg::*;

	batch_t                mux_batch;
	logic                  mux_valid;
	batch_t                batch_pipe [DAC_STAGES];
	logic [DAC_STAGES-1:0] valid_pipe;

	always_comb begin
		case (sel)
			src_rand: begin
				mux_batch = rand_in;
				mux_valid = rand_valid;
			end
			src_tri: begin
				mux_batch = tri_in;
				mux_valid = tri_valid;
			end
			src_pwl: begin
				mux_batch = pwl_in;
				mux_valid = pwl_valid;
			end
			default: begin
				mux_batch = '0;
				mux_valid = 1'b0;
			end
		endcase
	end

	// Fixed latency, the pipe never stalls and gaps travel as bubbles
	always_ff @(posedge clk) begin
		batch_pipe[0] <= mux_batch;
		for (int i = 1; i < DAC_STAGES; i++) begin
			batch_pipe[i] <= batch_pipe[i-1];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_pipe <= '0;
		end else begin
			valid_pipe[0] <= mux_valid;
			for (int i = 1; i < DAC_STAGES; i++) begin
				valid_pipe[i] <= valid_pipe[i-1];
			end
		end
	end

	assign dac_batch = batch_pipe[DAC_STAGES-1];
	assign dac_valid = valid_pipe[DAC_STAGES-1];

endmodule

// File: hdl/gen_control.sv
`timescale 1ns/100ps

module gen_control (
	input  logic                  clk,
	input  logic                  rst,
	input  host_cmd_pkg::host_cmd_t cmd,
	input  logic                  cmd_valid,
	input  logic                  dac_rdy,
	input  logic                  table_ready,
	output sample_pkg::src_sel_t  sel,
	output logic                  restart,
	output logic                  clear,
	output logic                  seed_load,
	output logic                  seg_wr,
	output logic                  adv_rand,
	output logic                  adv_tri,
	output logic                  adv_pwl,
	output sample_pkg::batch_t    seeds,
	output sample_pkg::pwl_seg_t  seg,
	output host_cmd_pkg::resp_t   resp,
	output logic                  resp_valid
);
	import sample_pkg::*;
	import host_cmd_pkg::*;

	logic is_reset;
	logic is_halt;
	logic ready_q;

	assign is_reset = cmd_valid && (cmd.opcode == op_reset);
	assign is_halt  = cmd_valid && (cmd.opcode == op_halt);

	// Strobes act in the command cycle itself
	assign restart   = rst || is_reset || is_halt;
	assign clear     = rst || is_reset;
	assign seed_load = cmd_valid && (cmd.opcode == op_load_seeds);
	assign seg_wr    = cmd_valid && (cmd.opcode == op_load_pwl);

	assign seeds = cmd.payload.seeds;
	assign seg   = cmd.payload.seg;

	// Loads and nop leave the running source alone
	always_ff @(posedge clk) begin
		if (rst) begin
			sel <= src_none;
		end else if (cmd_valid) begin
			case (cmd.opcode)
				op_reset, op_halt: sel <= src_none;
				op_run_rand:       sel <= src_rand;
				op_run_tri:        sel <= src_tri;
				op_run_pwl:        sel <= src_pwl;
				default:           sel <= sel;
			endcase
		end
	end

	assign adv_rand = (sel == src_rand) && dac_rdy;
	assign adv_tri  = (sel == src_tri) && dac_rdy;
	assign adv_pwl  = (sel == src_pwl) && dac_rdy;

	// One response per completed table, on the rise of table_ready
	always_ff @(posedge clk) begin
		if (rst) begin
			ready_q    <= 1'b0;
			resp_valid <= 1'b0;
		end else begin
			ready_q    <= table_ready;
			resp_valid <= table_ready && !ready_q;
		end
	end

	assign resp.pwl_ready = table_ready;
	assign resp.mode      = sel;

endmodule

// File: hdl/host_cmd_pkg.sv
package host_cmd_pkg;

	// Host opcodes
	// The run opcodes select a source and keep it until halt or reset
	typedef enum logic [2:0] {
		op_nop,
		op_reset,
		op_halt,
		op_run_rand,
		op_run_tri,
		op_run_pwl,
		op_load_seeds,
		op_load_pwl
	} opcode_t;

	// The 64-bit payload is read as LFSR seeds or as a PWL segment,
	// depending on the opcode
	typedef union packed {
		sample_pkg::batch_t   seeds;
		sample_pkg::pwl_seg_t seg;
	} cmd_payload_u;

	// Full command word as seen on the host port
	typedef struct packed {
		opcode_t      opcode;
		cmd_payload_u payload;
	} host_cmd_t;

	// Status returned to the host
	typedef struct packed {
		logic                 pwl_ready;
		sample_pkg::src_sel_t mode;
	} resp_t;

endpackage

// File: hdl/lfsr_bank.sv
`timescale 1ns/100ps

module lfsr_bank (
	input  logic               clk,
	input  logic               restart,
	input  logic               seed_load,
	input  logic               adv,
	input  sample_pkg::batch_t seeds,
	output sample_pkg::batch_t samples
);
	import sample_pkg::*;

	localparam sample_t TAPS = 16'hB400;

	batch_t state;

	// Right-shifting Galois step, taps folded in when bit 0 falls out
	function automatic sample_t lfsr_step(sample_t s);
		return (s >> 1) ^ (s[0] ? TAPS : sample_t'(0));
	endfunction

	always_ff @(posedge clk) begin
		for (int i = 0; i < BATCH_SIZE; i++) begin
			if (restart) begin
				state[i] <= sample_t'(i + 1);
			end else if (seed_load) begin
				// An all-zero state would never leave zero
				state[i] <= (seeds[i] == '0) ? sample_t'(1) : seeds[i];
			end else if (adv) begin
				state[i] <= lfsr_step(state[i]);
			end
		end
	end

	assign samples = state;

endmodule

// File: hdl/pwl_engine.sv
`timescale 1ns/100ps

module pwl_engine #(
	parameter int PWL_DEPTH = 16
) (
	input  logic                 clk,
	input  logic                 clear,
	input  logic                 restart,
	input  logic                 seg_wr,
	input  logic                 adv,
	input  sample_pkg::pwl_seg_t seg,
	output sample_pkg::batch_t   samples,
	output logic                 pwl_valid,
	output logic                 table_ready
);
	import sample_pkg::*;

	localparam int IDX_W = (PWL_DEPTH > 1) ? $clog2(PWL_DEPTH) : 1;
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(PWL_DEPTH - 1);

	pwl_seg_t         seg_mem [PWL_DEPTH];
	logic [IDX_W-1:0] wr_ptr;
	logic [IDX_W-1:0] rd_idx;
	logic [15:0]      batch_cnt;
	pwl_seg_t         cur;
	logic             seg_done;
	logic             wrap;

	always_ff @(posedge clk) begin
		if (seg_wr) begin
			seg_mem[wr_ptr] <= seg;
		end
	end

	// A last-flagged segment closes the table and rewinds the write pointer
	always_ff @(posedge clk) begin
		if (clear) begin
			wr_ptr      <= '0;
			table_ready <= 1'b0;
		end else if (seg_wr) begin
			if (seg.last) begin
				wr_ptr      <= '0;
				table_ready <= 1'b1;
			end else begin
				wr_ptr <= (wr_ptr == LAST_IDX) ? '0 : wr_ptr + 1'b1;
			end
		end
	end

	assign cur       = seg_mem[rd_idx];
	assign pwl_valid = adv && table_ready;

	// A length of zero plays like a length of one
	assign seg_done = (cur.length <= 16'd1) || (batch_cnt == cur.length - 16'd1);
	assign wrap     = cur.last || (rd_idx == LAST_IDX);

	always_ff @(posedge clk) begin
		if (restart) begin
			rd_idx    <= '0;
			batch_cnt <= '0;
		end else if (pwl_valid) begin
			if (seg_done) begin
				batch_cnt <= '0;
				rd_idx    <= wrap ? '0 : rd_idx + 1'b1;
			end else begin
				batch_cnt <= batch_cnt + 16'd1;
			end
		end
	end

	// Sample n of the segment is start + slope*n, kept to 16 bits
	always_comb begin
		logic [15:0] offset;
		for (int k = 0; k < BATCH_SIZE; k++) begin
			offset = {batch_cnt[13:0], 2'b00} + 16'(k);
			samples[k] = cur.start + $unsigned(cur.slope) * offset;
		end
	end

endmodule

// File: hdl/sample_generator.sv
`timescale 1ns/100ps

module sample_generator #(
	parameter int DAC_STAGES = 5,
	parameter int PWL_DEPTH  = 16
) (
	input  logic                    clk,
	input  logic                    rst,
	input  host_cmd_pkg::host_cmd_t cmd,
	input  logic                    cmd_valid,
	input  logic                    dac_rdy,
	output host_cmd_pkg::resp_t     resp,
	output logic                    resp_valid,
	output sample_pkg::batch_t      dac_batch,
	output logic                    dac_valid
);
	import sample_pkg::*;

	src_sel_t sel;
	logic     restart;
	logic     clear;
	logic     seed_load;
	logic     seg_wr;
	logic     adv_rand;
	logic     adv_tri;
	logic     adv_pwl;
	batch_t   seeds;
	pwl_seg_t seg;
	logic     table_ready;
	logic     pwl_valid;
	batch_t   rand_batch;
	batch_t   tri_batch;
	batch_t   pwl_batch;

	gen_control ctrl_i (
		.clk         (clk),
		.rst         (rst),
		.cmd         (cmd),
		.cmd_valid   (cmd_valid),
		.dac_rdy     (dac_rdy),
		.table_ready (table_ready),
		.sel         (sel),
		.restart     (restart),
		.clear       (clear),
		.seed_load   (seed_load),
		.seg_wr      (seg_wr),
		.adv_rand    (adv_rand),
		.adv_tri     (adv_tri),
		.adv_pwl     (adv_pwl),
		.seeds       (seeds),
		.seg         (seg),
		.resp        (resp),
		.resp_valid  (resp_valid)
	);

	lfsr_bank lfsr_i (
		.clk       (clk),
		.restart   (restart),
		.seed_load (seed_load),
		.adv       (adv_rand),
		.seeds     (seeds),
		.samples   (rand_batch)
	);

	triangle_wave tri_i (
		.clk     (clk),
		.restart (restart),
		.adv     (adv_tri),
		.samples (tri_batch)
	);

	pwl_engine #(
		.PWL_DEPTH (PWL_DEPTH)
	) pwl_i (
		.clk         (clk),
		.clear       (clear),
		.restart     (restart),
		.seg_wr      (seg_wr),
		.adv         (adv_pwl),
		.seg         (seg),
		.samples     (pwl_batch),
		.pwl_valid   (pwl_valid),
		.table_ready (table_ready)
	);

	// LFSR and triangle data is good whenever they advance
	dac_output_pipe #(
		.DAC_STAGES (DAC_STAGES)
	) pipe_i (
		.clk        (clk),
		.rst        (rst),
		.sel        (sel),
		.rand_in    (rand_batch),
		.tri_in     (tri_batch),
		.pwl_in     (pwl_batch),
		.rand_valid (adv_rand),
		.tri_valid  (adv_tri),
		.pwl_valid  (pwl_valid),
		.dac_batch  (dac_batch),
		.dac_valid  (dac_valid)
	);

endmodule

// File: hdl/sample_pkg.sv
package sample_pkg;

	// One DAC sample, unsigned offset binary
	typedef logic [15:0] sample_t;

	// Samples handed to the DAC per clock
	localparam int BATCH_SIZE = 4;

	// Lane 0 sits in the least significant word
	typedef sample_t [BATCH_SIZE-1:0] batch_t;

	// One linear piece of a PWL waveform
	// The length counts batches, so a segment covers 4*length samples
	typedef struct packed {
		sample_t            start;
		logic signed [15:0] slope;
		logic [15:0]        length;
		logic               last;
		logic [14:0]        pad;
	} pwl_seg_t;

	// Which generator feeds the DAC
	typedef enum logic [1:0] {
		src_none,
		src_rand,
		src_tri,
		src_pwl
	} src_sel_t;

endpackage

// File: hdl/triangle_wave.sv
`timescale 1ns/100ps

module triangle_wave (
	input  logic               clk,
	input  logic               restart,
	input  logic               adv,
	output sample_pkg::batch_t samples
);
	import sample_pkg::*;

	logic [16:0] phase;

	// The phase covers one full up and down sweep
	always_ff @(posedge clk) begin
		if (restart) begin
			phase <= '0;
		end else if (adv) begin
			phase <= phase + 17'(BATCH_SIZE);
		end
	end

	// Upper half of the sweep is mirrored to form the falling edge
	always_comb begin
		logic [16:0] p;
		for (int k = 0; k < BATCH_SIZE; k++) begin
			p = phase + 17'(k);
			samples[k] = p[16] ? ~p[15:0] : p[15:0];
		end
	end

endmodule

// File: sim.f
+incdir+include
hdl/sample_pkg.sv
hdl/host_cmd_pkg.sv
hdl/gen_control.sv
hdl/lfsr_bank.sv
hdl/triangle_wave.sv
hdl/pwl_engine.sv
hdl/dac_output_pipe.sv
hdl/sample_generator.sv
bench/sample_generator_properties.sv
bench/sample_generator_tb.sv
